/* list.f */
+incdir+sim
rtl/miner_pkg.sv
rtl/ocl_reg_slave.sv
rtl/sha_nonce_core.sv
rtl/nonce_collector.sv
rtl/miner_top.sv
sim/tb_miner_top.sv

/* rtl/miner_pkg.sv */
// Shared constants and types for the nonce search engine
// Address map assumes 32-bit word-aligned register accesses only

package miner_pkg;

  // ------------------------------------------------
  // Basic types
  // ------------------------------------------------
  typedef logic [31:0] word_t;
  typedef logic [31:0] addr_t;
  typedef logic [1:0]  resp_t;

  // Core sequencing
  typedef enum logic [1:0] {
    IDLE,
    ROUND,
    FINISH
  } core_state_t;

  // ------------------------------------------------
  // Search configuration
  // ------------------------------------------------
  localparam int N_CORES    = 4;
  localparam int ZERO_BITS  = 8;
  localparam int ROUNDS     = 64;
  localparam int MID_WORDS  = 8;
  localparam int TAIL_WORDS = 3;

  // Length word of the padded 80-byte header
  localparam word_t MSG_BITS = 32'd640;

  // Bus response, only OKAY is ever returned
  localparam resp_t RESP_OKAY = 2'b00;

  // ------------------------------------------------
  // Register map
  // ------------------------------------------------
  localparam addr_t ADDR_MID_BASE  = 32'h0000_0504;
  localparam addr_t ADDR_TAIL_BASE = 32'h0000_0524;
  localparam addr_t ADDR_TAIL_LAST = 32'h0000_052C;
  localparam addr_t ADDR_RESULT    = 32'h0000_0554;
  localparam addr_t ADDR_STATUS    = 32'h0000_0558;

  // Read value for anything not decoded
  localparam word_t RD_UNMAPPED = 32'hFFFF_FFFF;

  // ------------------------------------------------
  // SHA-256 constants
  // ------------------------------------------------
  localparam word_t SHA_K [ROUNDS] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
    32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
    32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
    32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
    32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
    32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // Initial hash value, used to build midstates
  localparam word_t SHA_H0 [MID_WORDS] = '{
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

endpackage

/* rtl/miner_top.sv */
`timescale 1ns/1ns
// Nonce search top, single clock; N_CORES cores share one job

module miner_top (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             awvalid,
  input  miner_pkg::addr_t awaddr,
  output logic             awready,
  input  logic             wvalid,
  input  miner_pkg::word_t wdata,
  output logic             wready,
  output logic             bvalid,
  output miner_pkg::resp_t bresp,
  input  logic             bready,
  input  logic             arvalid,
  input  miner_pkg::addr_t araddr,
  output logic             arready,
  output logic             rvalid,
  output miner_pkg::word_t rdata,
  output miner_pkg::resp_t rresp,
  input  logic             rready
);

  // Job words and search handshake
  miner_pkg::word_t              mid_words [miner_pkg::MID_WORDS];
  miner_pkg::word_t              tail_words [miner_pkg::TAIL_WORDS];
  logic                          start;
  logic                          halt;
  logic [miner_pkg::N_CORES-1:0] found;
  miner_pkg::word_t              nonce [miner_pkg::N_CORES];
  miner_pkg::word_t              result;
  logic                          result_valid;

  // ------------------------------------------------
  // Register port
  // ------------------------------------------------
  ocl_reg_slave u_ocl_reg_slave (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready),
    .mid_words       (mid_words),
    .tail_words      (tail_words),
    .start           (start),
    .result          (result),
    .result_valid    (result_valid)
  );

  // ------------------------------------------------
  // Hash cores, core i starts at nonce i
  // ------------------------------------------------
  for (genvar i = 0; i < miner_pkg::N_CORES; i++) begin : g_core
    sha_nonce_core #(
      .CORE_INDEX (i)
    ) u_core (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .mid_words       (mid_words),
      .tail_words      (tail_words),
      .start           (start),
      .halt            (halt),
      .found           (found[i]),
      .nonce           (nonce[i])
    );
  end

  // Winner selection
  nonce_collector u_nonce_collector (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .start           (start),
    .found           (found),
    .nonce           (nonce),
    .result          (result),
    .result_valid    (result_valid),
    .halt            (halt)
  );

endmodule

/* rtl/nonce_collector.sv */
`timescale 1ns/1ns
// Keeps the first winning nonce; cores run in lockstep, so lowest index is smallest

module nonce_collector (
  input  logic                          clk_main_a0,
  input  logic                          rst_main_n_sync,
  input  logic                          start,
  input  logic [miner_pkg::N_CORES-1:0] found,
  input  miner_pkg::word_t              nonce [miner_pkg::N_CORES],
  output miner_pkg::word_t              result,
  output logic                          result_valid,
  output logic                          halt
);

  miner_pkg::word_t sel_nonce;
  logic             capture;

  // Priority pick, lowest core index wins
  always_comb begin
    sel_nonce = '0;
    for (int i = miner_pkg::N_CORES - 1; i >= 0; i--) begin
      if (found[i]) begin
        sel_nonce = nonce[i];
      end
    end
  end

  // First hit of a job only, start has priority
  assign capture = (|found) && !result_valid && !start;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      result_valid <= 1'b0;
    end else if (start) begin
      result_valid <= 1'b0;
    end else if (capture) begin
      result_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (capture) begin
      result <= sel_nonce;
    end
  end

  // Cores stop for as long as a result is held
  assign halt = result_valid;

  // Every hit in one cycle carries at least the picked nonce
  for (genvar k = 0; k < miner_pkg::N_CORES; k++) begin : g_pick_chk
    a_pick_smallest: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
      found[k] |-> (sel_nonce <= nonce[k]));
  end

endmodule

/* rtl/ocl_reg_slave.sv */
`timescale 1ns/1ns
// Single-beat register port, one write and one read in flight at a time
// Full-word writes only; midstate must be written before the last tail word

module ocl_reg_slave (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  logic             awvalid,
  input  miner_pkg::addr_t awaddr,
  output logic             awready,
  input  logic             wvalid,
  input  miner_pkg::word_t wdata,
  output logic             wready,
  output logic             bvalid,
  output miner_pkg::resp_t bresp,
  input  logic             bready,
  input  logic             arvalid,
  input  miner_pkg::addr_t araddr,
  output logic             arready,
  output logic             rvalid,
  output miner_pkg::word_t rdata,
  output miner_pkg::resp_t rresp,
  input  logic             rready,
  output miner_pkg::word_t mid_words [miner_pkg::MID_WORDS],
  output miner_pkg::word_t tail_words [miner_pkg::TAIL_WORDS],
  output logic             start,
  input  miner_pkg::word_t result,
  input  logic             result_valid
);

  logic             wr_active;
  miner_pkg::addr_t wr_addr;
  logic             ar_take;
  logic             ar_pending;
  miner_pkg::addr_t ar_addr_q;
  miner_pkg::word_t rd_mux;

  // ------------------------------------------------
  // Write path
  // ------------------------------------------------
  // Active from address accept until response taken
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      wr_active <= 1'b0;
    end else if (wr_active && bvalid && bready) begin
      wr_active <= 1'b0;
    end else if (!wr_active && awvalid) begin
      wr_active <= 1'b1;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (awvalid && awready) begin
      wr_addr <= awaddr;
    end
  end

  assign awready = !wr_active;
  assign wready  = wr_active && wvalid;

  // Response one cycle after data, held until bready
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      bvalid <= 1'b0;
    end else if (bvalid && bready) begin
      bvalid <= 1'b0;
    end else if (!bvalid && wready) begin
      bvalid <= 1'b1;
    end
  end

  assign bresp = miner_pkg::RESP_OKAY;

  // Job words by address, unmapped writes fall through
  always_ff @(posedge clk_main_a0) begin
    if (wready) begin
      for (int i = 0; i < miner_pkg::MID_WORDS; i++) begin
        if (wr_addr == miner_pkg::ADDR_MID_BASE + miner_pkg::addr_t'(4 * i)) begin
          mid_words[i] <= wdata;
        end
      end
      for (int j = 0; j < miner_pkg::TAIL_WORDS; j++) begin
        if (wr_addr == miner_pkg::ADDR_TAIL_BASE + miner_pkg::addr_t'(4 * j)) begin
          tail_words[j] <= wdata;
        end
      end
    end
  end

  // Launch in the data cycle of the last tail word
  assign start = wready && (wr_addr == miner_pkg::ADDR_TAIL_LAST);

  // ------------------------------------------------
  // Read path
  // ------------------------------------------------
  assign arready = !ar_pending && !rvalid;
  assign ar_take = arvalid && arready;

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      ar_pending <= 1'b0;
    end else begin
      ar_pending <= ar_take;
    end
  end

  always_ff @(posedge clk_main_a0) begin
    if (ar_take) begin
      ar_addr_q <= araddr;
    end
  end

  // Result, found flag in bit 0, or the unmapped pattern
  always_comb begin
    case (ar_addr_q)
      miner_pkg::ADDR_RESULT: rd_mux = result;
      miner_pkg::ADDR_STATUS: rd_mux = miner_pkg::word_t'(result_valid);
      default:                rd_mux = miner_pkg::RD_UNMAPPED;
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      rvalid <= 1'b0;
    end else if (rvalid && rready) begin
      rvalid <= 1'b0;
    end else if (ar_pending) begin
      rvalid <= 1'b1;
    end
  end

  // Data holds while the host stalls rready
  always_ff @(posedge clk_main_a0) begin
    if (ar_pending) begin
      rdata <= rd_mux;
    end
  end

  assign rresp = miner_pkg::RESP_OKAY;

  // A second data beat must not land on a pending response
  a_no_resp_overrun: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    (bvalid && !bready) |-> !wready);

endmodule

/* rtl/sha_nonce_core.sv */
`timescale 1ns/1ns
// Iterative SHA-256 over the final header chunk, one round per cycle
// Midstate must stay stable during a search; a hit is assumed before the nonce wraps

module sha_nonce_core #(
  parameter int CORE_INDEX = 0
) (
  input  logic             clk_main_a0,
  input  logic             rst_main_n_sync,
  input  miner_pkg::word_t mid_words [miner_pkg::MID_WORDS],
  input  miner_pkg::word_t tail_words [miner_pkg::TAIL_WORDS],
  input  logic             start,
  input  logic             halt,
  output logic             found,
  output miner_pkg::word_t nonce
);

  localparam int RND_W = $clog2(miner_pkg::ROUNDS);
  localparam logic [RND_W-1:0] LAST_RND = RND_W'(miner_pkg::ROUNDS - 1);

  miner_pkg::core_state_t state;
  logic [RND_W-1:0]       rnd;
  miner_pkg::word_t       a, b, c, d, e, f, g, h;
  miner_pkg::word_t       w_win [16];
  miner_pkg::word_t       w_cur;
  miner_pkg::word_t       t1, t2;
  miner_pkg::word_t       digest0;
  logic                   hit;
  logic                   restart;
  logic                   load;

  // ------------------------------------------------
  // SHA-256 helper functions
  // ------------------------------------------------
  function automatic miner_pkg::word_t rotr(miner_pkg::word_t x, int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic miner_pkg::word_t big_sig0(miner_pkg::word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic miner_pkg::word_t big_sig1(miner_pkg::word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic miner_pkg::word_t small_sig0(miner_pkg::word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic miner_pkg::word_t small_sig1(miner_pkg::word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  // ------------------------------------------------
  // Message schedule
  // ------------------------------------------------
  // First 16 words straight from the padded chunk, then the rolling window
  always_comb begin
    if (rnd < RND_W'(16)) begin
      case (rnd[3:0])
        4'd0:    w_cur = tail_words[0];
        4'd1:    w_cur = tail_words[1];
        4'd2:    w_cur = tail_words[2];
        4'd3:    w_cur = nonce;
        4'd4:    w_cur = 32'h8000_0000;
        4'd15:   w_cur = miner_pkg::MSG_BITS;
        default: w_cur = '0;
      endcase
    end else begin
      // Window slot 0 is W[t-16], slot 15 is W[t-1]
      w_cur = small_sig1(w_win[14]) + w_win[9] + small_sig0(w_win[1]) + w_win[0];
    end
  end

  // Round sums
  assign t1 = h + big_sig1(e) + ((e & f) ^ (~e & g)) + miner_pkg::SHA_K[rnd] + w_cur;
  assign t2 = big_sig0(a) + ((a & b) ^ (a & c) ^ (b & c));

  // Only the first digest word matters for the difficulty test
  assign digest0 = mid_words[0] + a;
  assign hit     = (digest0[31 -: miner_pkg::ZERO_BITS] == '0);
  assign found   = (state == miner_pkg::FINISH) && hit;

  // Next nonce of this core's series unless someone already won
  assign restart = (state == miner_pkg::FINISH) && !hit && !halt;
  assign load    = start || restart;

  // ------------------------------------------------
  // Control
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state <= miner_pkg::IDLE;
      rnd   <= '0;
      nonce <= '0;
    end else if (start) begin
      // New job overrides any search in flight
      state <= miner_pkg::ROUND;
      rnd   <= '0;
      nonce <= miner_pkg::word_t'(CORE_INDEX);
    end else begin
      case (state)
        miner_pkg::ROUND: begin
          if (halt) begin
            state <= miner_pkg::IDLE;
          end else begin
            rnd <= rnd + 1'b1;
            if (rnd == LAST_RND) begin
              state <= miner_pkg::FINISH;
            end
          end
        end
        miner_pkg::FINISH: begin
          if (restart) begin
            state <= miner_pkg::ROUND;
            rnd   <= '0;
            nonce <= nonce + miner_pkg::word_t'(miner_pkg::N_CORES);
          end else begin
            state <= miner_pkg::IDLE;
          end
        end
        default: state <= miner_pkg::IDLE;
      endcase
    end
  end

  // ------------------------------------------------
  // Datapath
  // ------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (load) begin
      a <= mid_words[0];
      b <= mid_words[1];
      c <= mid_words[2];
      d <= mid_words[3];
      e <= mid_words[4];
      f <= mid_words[5];
      g <= mid_words[6];
      h <= mid_words[7];
    end else if (state == miner_pkg::ROUND) begin
      h <= g;
      g <= f;
      f <= e;
      e <= d + t1;
      d <= c;
      c <= b;
      b <= a;
      a <= t1 + t2;
      for (int i = 0; i < 15; i++) begin
        w_win[i] <= w_win[i + 1];
      end
      w_win[15] <= w_cur;
    end
  end

  // Hit reported only after a full run of rounds
  a_found_after_rounds: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    found |-> $past(state == miner_pkg::ROUND && rnd == '0, miner_pkg::ROUNDS));

endmodule

/* sim/tb_sha_model.svh */
// SHA-256 reference for the testbench, included inside the testbench module
// Search scans nonces upward from 0 and gives up after SEARCH_LIMIT candidates
`ifndef TB_SHA_MODEL_SVH
`define TB_SHA_MODEL_SVH

localparam int SEARCH_LIMIT = 1 << 20;

// Chaining value and chunk worked on by compress_block
miner_pkg::word_t model_state [8];
miner_pkg::word_t model_block [16];
// Job under test
miner_pkg::word_t model_mid [8];
miner_pkg::word_t model_tail [3];

// Galois LFSR, right shifting, one step per output bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

function automatic miner_pkg::word_t ror32(input miner_pkg::word_t x, input int n);
  logic [63:0] xx;
  xx = {x, x} >> n;
  return xx[31:0];
endfunction

// ------------------------------------------------
// One compression, model_state updated in place
// ------------------------------------------------
task automatic compress_block();
  miner_pkg::word_t w [64];
  miner_pkg::word_t v [8];
  miner_pkg::word_t s0, s1, ch, maj, tmp1, tmp2;
  for (int t = 0; t < 64; t++) begin
    if (t < 16) begin
      w[t] = model_block[t];
    end else begin
      s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
      s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
      w[t] = w[t-16] + s0 + w[t-7] + s1;
    end
  end
  for (int i = 0; i < 8; i++) begin
    v[i] = model_state[i];
  end
  for (int t = 0; t < 64; t++) begin
    s1   = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
    ch   = (v[4] & v[5]) ^ (~v[4] & v[6]);
    tmp1 = v[7] + s1 + ch + miner_pkg::SHA_K[t] + w[t];
    s0   = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
    maj  = (v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]);
    tmp2 = s0 + maj;
    v[7] = v[6];
    v[6] = v[5];
    v[5] = v[4];
    v[4] = v[3] + tmp1;
    v[3] = v[2];
    v[2] = v[1];
    v[1] = v[0];
    v[0] = tmp1 + tmp2;
  end
  for (int i = 0; i < 8; i++) begin
    model_state[i] = model_state[i] + v[i];
  end
endtask

// Smallest nonce whose first digest word has ZERO_BITS leading zeros
task automatic search_nonce(output miner_pkg::word_t n);
  miner_pkg::word_t cand;
  bit               hit;
  cand = '0;
  hit  = 1'b0;
  while (!hit) begin
    if (cand >= SEARCH_LIMIT) begin
      $display("Model search found no qualifying nonce below %0d", SEARCH_LIMIT);
      stop_run();
    end
    for (int i = 0; i < 8; i++) begin
      model_state[i] = model_mid[i];
    end
    for (int i = 0; i < 16; i++) begin
      model_block[i] = '0;
    end
    model_block[0]  = model_tail[0];
    model_block[1]  = model_tail[1];
    model_block[2]  = model_tail[2];
    model_block[3]  = cand;
    // Padding bit, then the 80-byte length in bits
    model_block[4]  = 32'h8000_0000;
    model_block[15] = 32'd640;
    compress_block();
    if ((model_state[0] >> (32 - miner_pkg::ZERO_BITS)) == 0) begin
      hit = 1'b1;
    end else begin
      cand = cand + 1;
    end
  end
  n = cand;
endtask

`endif

/* sim/tb_miner_top.sv */
`timescale 1ns/1ns
// Testbench for miner_top; job words from a fixed-seed LFSR, nonces from a SHA-256 model
// Outputs sampled at the falling edge, inputs driven 1 ns after the rising edge

module tb_miner_top;

  localparam int BUS_LIMIT    = 64;
  localparam int POLL_LIMIT   = 40000;
  // One batch is 64 rounds plus the finish cycle
  localparam int BATCH_CYCLES = miner_pkg::ROUNDS + 1;
  localparam int STALL_MARGIN = 8;

  // Handshake flags known to wait_flag
  localparam int FL_AWREADY = 0;
  localparam int FL_WREADY  = 1;
  localparam int FL_BVALID  = 2;
  localparam int FL_ARREADY = 3;
  localparam int FL_RVALID  = 4;

  typedef enum logic [1:0] {
    OP_WRITE,
    OP_READ,
    OP_POLL,
    OP_STALL
  } op_t;

  // For OP_STALL the data field is the number of held-off cycles
  typedef struct packed {
    op_t              kind;
    miner_pkg::addr_t addr;
    miner_pkg::word_t data;
    miner_pkg::word_t exp_val;
  } row_t;

  logic             clk_main_a0;
  logic             rst_main_n_sync;
  logic             awvalid;
  miner_pkg::addr_t awaddr;
  logic             awready;
  logic             wvalid;
  miner_pkg::word_t wdata;
  logic             wready;
  logic             bvalid;
  miner_pkg::resp_t bresp;
  logic             bready;
  logic             arvalid;
  miner_pkg::addr_t araddr;
  logic             arready;
  logic             rvalid;
  miner_pkg::word_t rdata;
  miner_pkg::resp_t rresp;
  logic             rready;

  row_t             rows [$];
  logic [31:0]      lfsr;

  `include "tb_sha_model.svh"

  miner_top u_miner_top (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .awvalid         (awvalid),
    .awaddr          (awaddr),
    .awready         (awready),
    .wvalid          (wvalid),
    .wdata           (wdata),
    .wready          (wready),
    .bvalid          (bvalid),
    .bresp           (bresp),
    .bready          (bready),
    .arvalid         (arvalid),
    .araddr          (araddr),
    .arready         (arready),
    .rvalid          (rvalid),
    .rdata           (rdata),
    .rresp           (rresp),
    .rready          (rready)
  );

  always #4 clk_main_a0 = ~clk_main_a0;

  // ------------------------------------------------
  // Failure handling and checks
  // ------------------------------------------------
  task automatic stop_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic check_value(input string what, input miner_pkg::word_t got,
                             input miner_pkg::word_t exp_val);
    assert (got === exp_val) else begin
      $display("Error at %0t ns: %s gave 0x%08h, expected 0x%08h", $time, what, got, exp_val);
      stop_run();
    end
  endtask

  function automatic logic flag_of(input int sel);
    case (sel)
      FL_AWREADY: return awready;
      FL_WREADY:  return wready;
      FL_BVALID:  return bvalid;
      FL_ARREADY: return arready;
      default:    return rvalid;
    endcase
  endfunction

  // Falling-edge sampling, bounded
  task automatic wait_flag(input int sel, input string what);
    int n;
    n = 0;
    @(negedge clk_main_a0);
    while (!flag_of(sel)) begin
      n++;
      if (n > BUS_LIMIT) begin
        $display("Timeout waiting for %s at %0t ns", what, $time);
        stop_run();
      end
      @(negedge clk_main_a0);
    end
  endtask

  // ------------------------------------------------
  // Bus tasks, entered 1 ns after a rising edge
  // ------------------------------------------------
  task automatic write_reg(input miner_pkg::addr_t addr, input miner_pkg::word_t data);
    awvalid = 1'b1;
    awaddr  = addr;
    wvalid  = 1'b1;
    wdata   = data;
    bready  = 1'b1;
    wait_flag(FL_AWREADY, "awready");
    @(posedge clk_main_a0);
    #1;
    awvalid = 1'b0;
    wait_flag(FL_WREADY, "wready");
    @(posedge clk_main_a0);
    #1;
    wvalid = 1'b0;
    wait_flag(FL_BVALID, "bvalid");
    check_value("bresp", miner_pkg::word_t'(bresp), miner_pkg::word_t'(miner_pkg::RESP_OKAY));
    @(posedge clk_main_a0);
    #1;
    bready = 1'b0;
  endtask

  task automatic read_reg(input miner_pkg::addr_t addr, input int stall,
                          output miner_pkg::word_t data);
    arvalid = 1'b1;
    araddr  = addr;
    rready  = (stall == 0);
    wait_flag(FL_ARREADY, "arready");
    @(posedge clk_main_a0);
    #1;
    arvalid = 1'b0;
    wait_flag(FL_RVALID, "rvalid");
    data = rdata;
    check_value("rresp", miner_pkg::word_t'(rresp), miner_pkg::word_t'(miner_pkg::RESP_OKAY));
    // Host holds off, response must not move
    for (int i = 0; i < stall; i++) begin
      @(negedge clk_main_a0);
      assert (rvalid && rdata === data) else begin
        $display("Error at %0t ns: read response changed while rready was low", $time);
        stop_run();
      end
    end
    if (stall > 0) begin
      @(posedge clk_main_a0);
      #1;
      rready = 1'b1;
    end
    @(posedge clk_main_a0);
    #1;
    rready = 1'b0;
  endtask

  task automatic poll_found();
    miner_pkg::word_t st;
    int               n;
    st = '0;
    n  = 0;
    while (st[0] !== 1'b1) begin
      if (n >= POLL_LIMIT) begin
        $display("Timeout: found flag not set after %0d status reads", POLL_LIMIT);
        stop_run();
      end
      read_reg(miner_pkg::ADDR_STATUS, 0, st);
      n++;
    end
  endtask

  // ------------------------------------------------
  // Table building
  // ------------------------------------------------
  task automatic add_row(input op_t kind, input miner_pkg::addr_t addr,
                         input miner_pkg::word_t data, input miner_pkg::word_t exp_val);
    row_t r;
    r.kind    = kind;
    r.addr    = addr;
    r.data    = data;
    r.exp_val = exp_val;
    rows.push_back(r);
  endtask

  // MSB first, one LFSR step per bit
  task automatic next_word(output miner_pkg::word_t w);
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w    = {w[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Midstate of a random first chunk, random tail, then the 11 job writes
  task automatic queue_job(output miner_pkg::word_t exp_nonce);
    for (int i = 0; i < 8; i++) begin
      model_state[i] = miner_pkg::SHA_H0[i];
    end
    for (int i = 0; i < 16; i++) begin
      next_word(model_block[i]);
    end
    compress_block();
    for (int i = 0; i < 8; i++) begin
      model_mid[i] = model_state[i];
    end
    for (int j = 0; j < 3; j++) begin
      next_word(model_tail[j]);
    end
    search_nonce(exp_nonce);
    for (int i = 0; i < 8; i++) begin
      add_row(OP_WRITE, miner_pkg::ADDR_MID_BASE + miner_pkg::addr_t'(4 * i), model_mid[i], '0);
    end
    // Last one lands on ADDR_TAIL_LAST and starts the search
    for (int j = 0; j < 3; j++) begin
      add_row(OP_WRITE, miner_pkg::ADDR_TAIL_BASE + miner_pkg::addr_t'(4 * j), model_tail[j], '0);
    end
  endtask

  initial begin
    row_t             r;
    miner_pkg::word_t got;
    miner_pkg::word_t n0, n1, n2, n3;
    miner_pkg::word_t stall_len;
    clk_main_a0     = 1'b0;
    rst_main_n_sync = 1'b0;
    awvalid         = 1'b0;
    awaddr          = '0;
    wvalid          = 1'b0;
    wdata           = '0;
    bready          = 1'b0;
    arvalid         = 1'b0;
    araddr          = '0;
    rready          = 1'b0;
    lfsr            = 32'd78;

    // Plain job, early status, unmapped read and write
    queue_job(n0);
    add_row(OP_READ, miner_pkg::ADDR_STATUS, '0, 32'd0);
    add_row(OP_READ, 32'h0000_0600, '0, miner_pkg::RD_UNMAPPED);
    add_row(OP_POLL, miner_pkg::ADDR_STATUS, '0, 32'd1);
    add_row(OP_READ, miner_pkg::ADDR_RESULT, '0, n0);
    add_row(OP_WRITE, 32'h0000_0530, 32'hdead_beef, '0);
    add_row(OP_READ, miner_pkg::ADDR_STATUS, '0, 32'd1);
    add_row(OP_READ, miner_pkg::ADDR_RESULT, '0, n0);
    // Second job overwrites the first while it runs
    queue_job(n1);
    queue_job(n2);
    add_row(OP_READ, miner_pkg::ADDR_STATUS, '0, 32'd0);
    add_row(OP_POLL, miner_pkg::ADDR_STATUS, '0, 32'd1);
    add_row(OP_READ, miner_pkg::ADDR_RESULT, '0, n2);
    // Stalled status read held past the batch that holds the winner
    queue_job(n3);
    stall_len = (n3 / miner_pkg::N_CORES + 1) * BATCH_CYCLES + STALL_MARGIN;
    add_row(OP_STALL, miner_pkg::ADDR_STATUS, stall_len, 32'd0);
    add_row(OP_POLL, miner_pkg::ADDR_STATUS, '0, 32'd1);
    add_row(OP_READ, miner_pkg::ADDR_RESULT, '0, n3);
    $display("Model nonces: %0d %0d %0d %0d", n0, n1, n2, n3);

    repeat (2) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;

    foreach (rows[i]) begin
      r = rows[i];
      case (r.kind)
        OP_WRITE: write_reg(r.addr, r.data);
        OP_READ: begin
          read_reg(r.addr, 0, got);
          check_value($sformatf("read of 0x%08h", r.addr), got, r.exp_val);
        end
        OP_STALL: begin
          read_reg(r.addr, int'(r.data), got);
          check_value($sformatf("stalled read of 0x%08h", r.addr), got, r.exp_val);
        end
        default: poll_found();
      endcase
    end

    $display("Simulation finished: PASS");
    $finish;
  end

endmodule
